/* cache_pkg.sv */
package cache_pkg;

   // data space byte address, the requester adds one select bit above it
   localparam int addr_w = 12;
   localparam int data_w = 32;
   localparam int nbytes = data_w / 8;

   // line geometry
   localparam int index_w = 4;
   localparam int offset_w = 2;
   localparam int byte_off_w = 2;
   localparam int tag_w = addr_w - index_w - offset_w - byte_off_w;

   localparam int nlines = 2 ** index_w;
   localparam int nwords = 2 ** offset_w;

   // bit positions of the address fields
   localparam int offset_lsb = byte_off_w;
   localparam int index_lsb = offset_lsb + offset_w;
   localparam int tag_lsb = index_lsb + index_w;

   // control register space
   localparam int ctrl_addr_w = 2;

   typedef enum logic [1:0] {
      idle,
      refill,
      write_through
   } backend_state_t;

   // invalidate and clear_counters act on writes only
   typedef enum logic [ctrl_addr_w-1:0] {
      read_hits      = 2'd0,
      read_misses    = 2'd1,
      invalidate     = 2'd2,
      clear_counters = 2'd3
   } ctrl_op_t;

endpackage

/* cache_front_end.sv */
`timescale 1ns/1ps

module cache_front_end
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [addr_w:0]        addr,
   input  logic [data_w-1:0]      wdata,
   input  logic [nbytes-1:0]      wstrb,
   input  logic                   req,
   output logic                   ack,
   output logic [data_w-1:0]      rdata,
   output logic                   data_req,
   output logic [addr_w-1:0]      data_addr,
   output logic                   data_req_reg,
   output logic [addr_w-1:0]      data_addr_reg,
   output logic [data_w-1:0]      data_wdata_reg,
   output logic [nbytes-1:0]      data_wstrb_reg,
   input  logic [data_w-1:0]      data_rdata,
   input  logic                   data_ack,
   output logic                   ctrl_req,
   output logic [ctrl_addr_w-1:0] ctrl_addr,
   input  logic [data_w-1:0]      ctrl_rdata,
   input  logic                   ctrl_ack
);

   logic ctrl_sel;
   logic data_req_int;

   // top address bit picks the control registers
   assign ctrl_sel = addr[addr_w];

   assign data_req_int = req && !ctrl_sel;
   assign ctrl_req = req && ctrl_sel;
   assign ctrl_addr = addr[ctrl_addr_w-1:0];

   // live request toward the cache, tags are read from it
   assign data_addr = addr[addr_w-1:0];
   assign data_req = data_req_int || data_req_reg;

   // result back to the requester
   assign ack = data_ack || ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         data_req_reg <= 1'b0;
      end else begin
         data_req_reg <= data_req_int;
      end
   end

   // request fields, compared one cycle later
   always_ff @(posedge clk) begin
      data_addr_reg <= addr[addr_w-1:0];
      data_wdata_reg <= wdata;
      data_wstrb_reg <= wstrb;
   end

   // only one side may answer a given request
   ack_one_side: assert property (
      @(posedge clk) disable iff (reset)
      !(data_ack && ctrl_ack)
   );

endmodule

/* cache_memory.sv */
`timescale 1ns/1ps

module cache_memory
   import cache_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                data_req,
   input  logic [addr_w-1:0]   data_addr,
   input  logic                data_req_reg,
   input  logic [addr_w-1:0]   data_addr_reg,
   input  logic [data_w-1:0]   data_wdata_reg,
   input  logic [nbytes-1:0]   data_wstrb_reg,
   output logic                data_ack,
   output logic [data_w-1:0]   data_rdata,
   output logic                hit,
   output logic                miss,
   input  logic                invalidate_all,
   output logic                refill_req,
   output logic                wt_req,
   output logic [addr_w-1:0]   miss_addr,
   output logic [data_w-1:0]   wt_wdata,
   output logic [nbytes-1:0]   wt_wstrb,
   input  logic                refill_we,
   input  logic [offset_w-1:0] refill_offset,
   input  logic [data_w-1:0]   refill_data,
   input  logic                refill_done,
   input  logic                wt_done
);

   logic [tag_w-1:0]    tag_mem [nlines];
   logic [data_w-1:0]   data_mem [nlines*nwords];
   logic [nlines-1:0]   valid;
   logic [tag_w-1:0]    tag_rd;
   logic [data_w-1:0]   data_rd;
   logic [index_w-1:0]  idx_live;
   logic [offset_w-1:0] off_live;
   logic [index_w-1:0]  idx_reg;
   logic [offset_w-1:0] off_reg;
   logic [tag_w-1:0]    tag_reg;
   logic                is_write;
   logic                tag_match;
   logic                access;
   logic                first;
   logic                busy;
   logic                ack_q;
   logic                done_q;

   assign idx_live = data_addr[index_lsb +: index_w];
   assign off_live = data_addr[offset_lsb +: offset_w];
   assign idx_reg = data_addr_reg[index_lsb +: index_w];
   assign off_reg = data_addr_reg[offset_lsb +: offset_w];
   assign tag_reg = data_addr_reg[tag_lsb +: tag_w];

   assign is_write = |data_wstrb_reg;
   assign tag_match = valid[idx_reg] && (tag_rd == tag_reg);

   // the registered request lingers one cycle past ack, skip that cycle
   assign access = data_req_reg && !ack_q;
   assign first = access && !busy;

   // one lookup per access
   assign hit = first && tag_match;
   assign miss = first && !tag_match;

   assign refill_req = miss && !is_write;
   assign wt_req = first && is_write;

   // line address for a refill, word address for a store
   assign miss_addr = is_write ?
                      {data_addr_reg[addr_w-1:offset_lsb], {offset_lsb{1'b0}}} :
                      {data_addr_reg[addr_w-1:index_lsb], {index_lsb{1'b0}}};
   assign wt_wdata = data_wdata_reg;
   assign wt_wstrb = data_wstrb_reg;

   // read hit acks at once, everything else after the backend finishes
   assign data_ack = (hit && !is_write) || done_q;
   assign data_rdata = data_rd;

   // array reads follow the live address, ready for the registered compare
   always_ff @(posedge clk) begin
      if (data_req) begin
         tag_rd <= tag_mem[idx_live];
         data_rd <= data_mem[{idx_live, off_live}];
      end
   end

   // refill words and strobed write hits
   always_ff @(posedge clk) begin
      if (refill_we) begin
         data_mem[{idx_reg, refill_offset}] <= refill_data;
      end else if (hit && is_write) begin
         for (int b = 0; b < nbytes; b++) begin
            if (data_wstrb_reg[b]) begin
               data_mem[{idx_reg, off_reg}][8*b +: 8] <= data_wdata_reg[8*b +: 8];
            end
         end
      end
      if (refill_done) begin
         tag_mem[idx_reg] <= tag_reg;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid <= '0;
         busy <= 1'b0;
         ack_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         ack_q <= data_ack;
         done_q <= refill_done || wt_done;
         if (refill_req || wt_req) begin
            busy <= 1'b1;
         end else if (done_q) begin
            busy <= 1'b0;
         end
         // line is unusable while it is being refilled
         if (invalidate_all) begin
            valid <= '0;
         end else if (refill_req) begin
            valid[idx_reg] <= 1'b0;
         end else if (refill_done) begin
            valid[idx_reg] <= 1'b1;
         end
      end
   end

   // at most one lookup for each request
   one_lookup_per_access: assert property (
      @(posedge clk) disable iff (reset)
      (hit || miss) |=> !(hit || miss)
   );

endmodule

/* cache_backend.sv */
`timescale 1ns/1ps

module cache_backend
   import cache_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                refill_req,
   input  logic                wt_req,
   input  logic [addr_w-1:0]   miss_addr,
   input  logic [data_w-1:0]   wt_wdata,
   input  logic [nbytes-1:0]   wt_wstrb,
   output logic                refill_we,
   output logic [offset_w-1:0] refill_offset,
   output logic [data_w-1:0]   refill_data,
   output logic                refill_done,
   output logic                wt_done,
   output logic                mem_req,
   output logic [addr_w-1:0]   mem_addr,
   output logic [data_w-1:0]   mem_wdata,
   output logic [nbytes-1:0]   mem_wstrb,
   input  logic [data_w-1:0]   mem_rdata,
   input  logic                mem_ack
);

   backend_state_t      state;
   logic [addr_w-1:0]   addr_reg;
   logic [offset_w-1:0] word_cnt;
   logic [data_w-1:0]   wdata_reg;
   logic [nbytes-1:0]   wstrb_reg;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= idle;
         word_cnt <= '0;
         refill_done <= 1'b0;
         wt_done <= 1'b0;
      end else begin
         refill_done <= 1'b0;
         wt_done <= 1'b0;
         case (state)
            idle: begin
               word_cnt <= '0;
               if (refill_req) begin
                  state <= refill;
               end else if (wt_req) begin
                  state <= write_through;
               end
            end
            refill: begin
               if (mem_ack) begin
                  word_cnt <= word_cnt + 1'b1;
                  // last word of the line
                  if (word_cnt == offset_w'(nwords - 1)) begin
                     state <= idle;
                     refill_done <= 1'b1;
                  end
               end
            end
            write_through: begin
               if (mem_ack) begin
                  state <= idle;
                  wt_done <= 1'b1;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // miss address and store data
   always_ff @(posedge clk) begin
      if (state == idle && (refill_req || wt_req)) begin
         addr_reg <= miss_addr;
         wdata_reg <= wt_wdata;
         wstrb_reg <= wt_wstrb;
      end
   end

   assign mem_req = (state != idle);
   // refill walks the words of the line in ascending order
   assign mem_addr = (state == refill) ?
                     {addr_reg[addr_w-1:index_lsb], word_cnt, {offset_lsb{1'b0}}} :
                     addr_reg;
   assign mem_wdata = wdata_reg;
   assign mem_wstrb = (state == write_through) ? wstrb_reg : '0;

   // each word goes into the line as it arrives
   assign refill_we = (state == refill) && mem_ack;
   assign refill_offset = word_cnt;
   assign refill_data = mem_rdata;

   mem_req_held: assert property (
      @(posedge clk) disable iff (reset)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr)
   );

   // the cache never misses again before the previous transfer is done
   new_miss_when_idle: assert property (
      @(posedge clk) disable iff (reset)
      (refill_req || wt_req) |-> state == idle
   );

endmodule

/* cache_control.sv */
`timescale 1ns/1ps

module cache_control
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   ctrl_req,
   input  logic [ctrl_addr_w-1:0] ctrl_addr,
   input  logic [nbytes-1:0]      data_wstrb_reg,
   input  logic                   hit,
   input  logic                   miss,
   output logic                   ctrl_ack,
   output logic [data_w-1:0]      ctrl_rdata,
   output logic                   invalidate_all
);

   ctrl_op_t          op;
   logic              ctrl_write;
   logic [data_w-1:0] hit_cnt;
   logic [data_w-1:0] miss_cnt;

   assign op = ctrl_op_t'(ctrl_addr);

   // strobes of this request sit in the front end register by the ack cycle
   assign ctrl_write = ctrl_ack && (|data_wstrb_reg);
   assign invalidate_all = ctrl_write && (op == invalidate);

   assign ctrl_rdata = (op == read_misses) ? miss_cnt : hit_cnt;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ack <= 1'b0;
         hit_cnt <= '0;
         miss_cnt <= '0;
      end else begin
         // request is still held during ack, so no back-to-back ack
         ctrl_ack <= ctrl_req && !ctrl_ack;
         if (ctrl_write && op == clear_counters) begin
            hit_cnt <= '0;
            miss_cnt <= '0;
         end else begin
            if (hit) begin
               hit_cnt <= hit_cnt + 1'b1;
            end
            if (miss) begin
               miss_cnt <= miss_cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic [addr_w:0]   addr,
   input  logic [data_w-1:0] wdata,
   input  logic [nbytes-1:0] wstrb,
   input  logic              req,
   output logic              ack,
   output logic [data_w-1:0] rdata,
   output logic              mem_req,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   output logic [nbytes-1:0] mem_wstrb,
   input  logic [data_w-1:0] mem_rdata,
   input  logic              mem_ack
);

   // front end to cache memory
   logic                   data_req;
   logic [addr_w-1:0]      data_addr;
   logic                   data_req_reg;
   logic [addr_w-1:0]      data_addr_reg;
   logic [data_w-1:0]      data_wdata_reg;
   logic [nbytes-1:0]      data_wstrb_reg;
   logic [data_w-1:0]      data_rdata;
   logic                   data_ack;

   // front end to control registers
   logic                   ctrl_req;
   logic [ctrl_addr_w-1:0] ctrl_addr;
   logic [data_w-1:0]      ctrl_rdata;
   logic                   ctrl_ack;

   // statistics and invalidate
   logic                   hit;
   logic                   miss;
   logic                   invalidate_all;

   // cache memory and backend
   logic                   refill_req;
   logic                   wt_req;
   logic [addr_w-1:0]      miss_addr;
   logic [data_w-1:0]      wt_wdata;
   logic [nbytes-1:0]      wt_wstrb;
   logic                   refill_we;
   logic [offset_w-1:0]    refill_offset;
   logic [data_w-1:0]      refill_data;
   logic                   refill_done;
   logic                   wt_done;

   cache_front_end i_cache_front_end (.*);

   cache_memory i_cache_memory (.*);

   cache_backend i_cache_backend (.*);

   cache_control i_cache_control (.*);

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache
   import cache_pkg::*;
();

   logic              clk;
   logic              reset;
   logic [addr_w:0]   addr;
   logic [data_w-1:0] wdata;
   logic [nbytes-1:0] wstrb;
   logic              req;
   logic              ack;
   logic [data_w-1:0] rdata;
   logic              mem_req;
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic [nbytes-1:0] mem_wstrb;
   logic [data_w-1:0] mem_rdata = '0;
   logic              mem_ack = 1'b0;

   // external memory model
   logic [data_w-1:0] mem_model [2**(addr_w-2)];
   logic [31:0]       lfsr_state;
   logic [2:0]        rand_bits;
   logic [3:0]        delay_left;
   logic              pending;
   logic [data_w-1:0] merged;

   // accesses from the golden file
   logic [31:0]       gold_op [$];
   logic [31:0]       gold_addr [$];
   logic [31:0]       gold_wdata [$];
   logic [31:0]       gold_wstrb [$];
   logic [31:0]       gold_rdata [$];

   // which lines the cache should hold, for the expected ack latency
   logic [nlines-1:0] line_valid;
   logic [tag_w-1:0]  line_tags [nlines];

   int                cycle_count = 0;
   int                timeout_cycles = 200;

   cache_top i_cache_top (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   // memory answers after 1 to 8 cycles, word index times 3 after reset
   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 2**(addr_w-2); i++) begin
            mem_model[i] <= data_w'(i * 3);
         end
         lfsr_state = 32'hb4a1;
         mem_ack <= 1'b0;
         pending <= 1'b0;
         delay_left <= '0;
      end else if (mem_ack) begin
         mem_ack <= 1'b0;
      end else if (mem_req && !pending) begin
         for (int i = 0; i < 3; i++) begin
            rand_bits = {rand_bits[1:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
         end
         delay_left <= {1'b0, rand_bits} + 4'd1;
         pending <= 1'b1;
      end else if (pending) begin
         if (delay_left == 4'd1) begin
            mem_rdata <= mem_model[mem_addr[addr_w-1:2]];
            if (|mem_wstrb) begin
               merged = mem_model[mem_addr[addr_w-1:2]];
               for (int b = 0; b < nbytes; b++) begin
                  if (mem_wstrb[b]) begin
                     merged[8*b +: 8] = mem_wdata[8*b +: 8];
                  end
               end
               mem_model[mem_addr[addr_w-1:2]] <= merged;
            end
            mem_ack <= 1'b1;
            pending <= 1'b0;
         end else begin
            delay_left <= delay_left - 4'd1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
         $display("Something failed");
         $fatal(1, "run did not finish in time");
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual,
                  expected);
         $display("Something failed");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic read_stimulus();
      int          fd;
      int          fields;
      string       text;
      logic [31:0] f_op;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_wstrb;
      logic [31:0] f_rdata;
      fd = $fopen("cache_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open cache_golden.txt");
         $display("Something failed");
         $fatal(1, "no stimulus");
      end else begin
         while ($fgets(text, fd) != 0) begin
            // comment and blank lines do not parse
            fields = $sscanf(text, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_wstrb, f_rdata);
            if (fields == 5) begin
               gold_op.push_back(f_op);
               gold_addr.push_back(f_addr);
               gold_wdata.push_back(f_wdata);
               gold_wstrb.push_back(f_wstrb);
               gold_rdata.push_back(f_rdata);
            end
         end
         $fclose(fd);
         if (gold_op.size() == 0) begin
            $display("cache_golden.txt holds no accesses");
            $display("Something failed");
            $fatal(1, "empty stimulus");
         end
      end
   endtask

   task automatic run_access(input int n);
      int                 wait_cycles;
      logic [data_w-1:0]  got;
      logic [31:0]        op_word;
      logic [31:0]        req_addr;
      logic [31:0]        strb_word;
      logic               is_ctrl;
      logic               is_write;
      logic               was_cached;
      logic [index_w-1:0] line_idx;
      logic [tag_w-1:0]   line_tag;
      op_word = gold_op[n];
      req_addr = gold_addr[n];
      strb_word = gold_wstrb[n];
      is_ctrl = op_word[0];
      is_write = |strb_word[nbytes-1:0];
      line_idx = req_addr[index_lsb +: index_w];
      line_tag = req_addr[tag_lsb +: tag_w];
      was_cached = line_valid[line_idx] && (line_tags[line_idx] == line_tag);

      @(posedge clk);
      req <= 1'b1;
      addr <= req_addr[addr_w:0];
      wdata <= gold_wdata[n];
      wstrb <= strb_word[nbytes-1:0];

      // request held until ack, sampled away from the rising edge
      wait_cycles = 0;
      @(negedge clk);
      while (!ack) begin
         wait_cycles++;
         @(negedge clk);
      end
      got = rdata;
      @(posedge clk);
      req <= 1'b0;
      wstrb <= '0;

      // read hits and control accesses answer in the next cycle
      if (is_ctrl || (!is_write && was_cached)) begin
         check_value(wait_cycles, 32'd1,
                     $sformatf("access %0d addr %h, ack latency", n, req_addr[addr_w:0]));
      end else begin
         check_value(32'(wait_cycles > 1), 32'd1,
                     $sformatf("access %0d addr %h, ack too early", n, req_addr[addr_w:0]));
      end
      if (!is_write) begin
         check_value(got, gold_rdata[n],
                     $sformatf("access %0d addr %h, read data", n, req_addr[addr_w:0]));
      end

      if (is_ctrl && is_write && ctrl_op_t'(req_addr[ctrl_addr_w-1:0]) == invalidate) begin
         line_valid = '0;
      end else if (!is_ctrl && !is_write && !was_cached) begin
         line_valid[line_idx] = 1'b1;
         line_tags[line_idx] = line_tag;
      end
   endtask

   initial begin
      reset = 1'b1;
      req = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      line_valid = '0;
      read_stimulus();
      timeout_cycles = gold_op.size() * 64 + 200;

      repeat (5) @(posedge clk);
      reset <= 1'b0;

      for (int n = 0; n < gold_op.size(); n++) begin
         run_access(n);
      end
      repeat (2) @(posedge clk);
      $display("Everything OK");
      $finish;
   end

endmodule

/* cache_golden.txt */
// op (0 data, 1 control) addr wdata wstrb expected_rdata, all hex
// expected_rdata is ignored for writes, a nonzero wstrb marks a write
0 010 00000000 0 0000000c
0 01c 00000000 0 00000015
0 014 00000000 0 0000000f
0 018 aabbccdd 5 00000000
0 018 00000000 0 00bb00dd
0 234 12345678 f 00000000
0 234 00000000 0 12345678
0 230 00000000 0 000001a4
1 1000 00000000 0 00000005
1 1001 00000000 0 00000003
0 110 00000000 0 000000cc
0 018 00000000 0 00bb00dd
1 1002 00000000 f 00000000
0 234 00000000 0 12345678
0 01c 00000000 0 00000015
1 1000 00000000 0 00000005
1 1001 00000000 0 00000007
1 1003 00000000 f 00000000
1 1000 00000000 0 00000000
1 1001 00000000 0 00000000
0 ff0 cafe0000 c 00000000
0 ff0 00000000 0 cafe0bf4
0 ff4 00000000 0 00000bf7
1 1000 00000000 0 00000001
1 1001 00000000 0 00000002

/* tb.f */
cache_pkg.sv
cache_front_end.sv
cache_memory.sv
cache_backend.sv
cache_control.sv
cache_top.sv
tb_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_cache

./obj_dir/Vtb_cache
